// File: tb.f
+incdir+.
crc_pkg.sv
host_interface.sv
crc_datapath.sv
crc_ahb_top.sv
tb_clock_gen.sv
tb_crc.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f tb.f --top-module tb_crc -o tb_crc_sim
	./obj_dir/tb_crc_sim | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module tb_crc

clean:
	rm -rf obj_dir sim.log

// File: tb_crc.sv
// Testbench for the AHB-Lite CRC engine with a bit-serial reference model
`timescale 1ns/1ns
`include "crc_defines.svh"

module tb_crc;

	import crc_pkg::*;

	// Register byte addresses
	localparam logic [31:0] A_DR    = 32'h00;
	localparam logic [31:0] A_IDR   = 32'h04;
	localparam logic [31:0] A_CR    = 32'h08;
	localparam logic [31:0] A_UNMAP = 32'h0C;
	localparam logic [31:0] A_INIT  = 32'h10;
	localparam logic [31:0] A_POL   = 32'h14;

	logic        HCLK;
	logic        HRESETn;
	logic        HSElx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic [2:0]  HSIZE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	integer      seed;
	int          errors;
	int          checks;
	int          tests;
	int          test_base;
	logic [31:0] cur_init;
	logic [31:0] cur_poly;

	// Beats folded since the last restart
	logic [31:0] beat_data [$];
	logic [1:0]  beat_size [$];

	// Read results waiting for the compare process
	logic [31:0] exp_q [$];
	logic [31:0] got_q [$];
	string       name_q [$];
	event        cmp_ev;

	tb_clock_gen clk_gen0 (.HCLK(HCLK), .HRESETn(HRESETn));

	crc_ahb_top dut0 (.*);

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic int width_of(input logic [1:0] ps);
		case (ps)
			2'd1:    return 16;
			2'd2:    return 8;
			2'd3:    return 7;
			default: return 32;
		endcase
	endfunction

	// Bit-serial CRC over the beat list, top bit of each beat first
	function automatic logic [31:0] crc_model(input logic [31:0] poly, input int width,
		input logic [31:0] init, input logic [1:0] rev_in, input logic rev_out,
		input logic [31:0] data [$], input logic [1:0] size [$]);
		logic [31:0] mask;
		logic [31:0] crc;
		logic [31:0] d;
		logic [31:0] r;
		int          nbits;
		int          grp;
		logic        fb;
		mask = (width == 32) ? 32'hFFFF_FFFF : ((32'd1 << width) - 32'd1);
		crc  = init & mask;
		foreach (data[k])
		begin
			nbits = 8 << size[k];
			d     = data[k] & (32'hFFFF_FFFF >> (32 - nbits));
			// Reversal group, never wider than the beat
			case (rev_in)
				2'd1:    grp = 8;
				2'd2:    grp = 16;
				2'd3:    grp = 32;
				default: grp = 0;
			endcase
			if (grp > nbits)
				grp = nbits;
			r = d;
			if (grp != 0)
				for (int base = 0; base < nbits; base += grp)
					for (int j = 0; j < grp; j++)
						r[base + j] = d[base + grp - 1 - j];
			for (int b = nbits - 1; b >= 0; b--)
			begin
				fb  = crc[width - 1] ^ r[b];
				crc = (crc << 1) & mask;
				if (fb)
					crc = crc ^ (poly & mask);
			end
		end
		if (rev_out)
		begin
			r = 32'h0;
			for (int b = 0; b < width; b++)
				r[b] = crc[width - 1 - b];
			crc = r;
		end
		return crc;
	endfunction

	////////////////////////////////////////
	// AHB driver
	////////////////////////////////////////

	// One NONSEQ transfer, address phase then data phase
	task automatic bus_xfer(input logic wr, input logic [31:0] addr, input logic [2:0] size,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		@(negedge HCLK);
		HSElx  = 1'b1;
		HADDR  = addr;
		HTRANS = NONSEQ;
		HWRITE = wr;
		HSIZE  = size;
		@(negedge HCLK);
		HSElx  = 1'b0;
		HTRANS = IDLE;
		HWDATA = wr ? wdata : 32'h0;
		#1;
		waited = 0;
		// Data phase ends at the first rising edge with HREADYOUT high
		while (!HREADYOUT && waited < 50)
		begin
			@(negedge HCLK);
			#1;
			waited++;
		end
		if (!HREADYOUT)
		begin
			$display("Timeout at %0t: HREADYOUT stayed low on the transfer to %h", $time, addr);
			$display("** FAIL **");
			$finish;
		end
		else
		begin
			rdata = HRDATA;
			assert (HRESP == 1'b0)
			else
			begin
				$display("[FAIL] %0t HRESP expected 0 got %b", $time, HRESP);
				errors++;
			end
		end
	endtask

	task automatic write_reg(input logic [31:0] addr, input logic [2:0] size,
		input logic [31:0] data);
		logic [31:0] unused;
		bus_xfer(1'b1, addr, size, data, unused);
	endtask

	// Read a register and hand it to the compare process
	task automatic read_check(input logic [31:0] addr, input string name,
		input logic [31:0] exp);
		logic [31:0] got;
		bus_xfer(1'b0, addr, 3'd2, 32'h0, got);
		exp_q.push_back(exp);
		got_q.push_back(got);
		name_q.push_back(name);
		-> cmp_ev;
	endtask

	task automatic push_beat(input logic [2:0] size, input logic [31:0] data);
		beat_data.push_back(data);
		beat_size.push_back(size[1:0]);
		write_reg(A_DR, size, data);
	endtask

	// CR write with bit 0 set, new config and a fresh chain
	task automatic restart_chain(input logic [1:0] ps, input logic [1:0] rin, input logic rout);
		write_reg(A_CR, 3'd2, {24'h0, rout, rin, ps, 3'b001});
		beat_data.delete();
		beat_size.delete();
	endtask

	task automatic random_beats(input int n);
		logic [31:0] rnd;
		logic [2:0]  sz;
		for (int i = 0; i < n; i++)
		begin
			rnd = $random(seed);
			sz  = (rnd[1:0] == 2'd3) ? 3'd2 : {1'b0, rnd[1:0]};
			push_beat(sz, $random(seed));
		end
	endtask

	task automatic check_crc(input logic [1:0] ps, input logic [1:0] rin, input logic rout);
		read_check(A_DR, "DR", crc_model(cur_poly, width_of(ps), cur_init, rin, rout,
			beat_data, beat_size));
	endtask

	task automatic end_test(input string title);
		// Let the compare process drain first
		@(negedge HCLK);
		tests++;
		$display("Test %0d %s: %s", tests, title, (errors == test_base) ? "ok" : "errors");
		test_base = errors;
	endtask

	////////////////////////////////////////
	// Compare process
	////////////////////////////////////////

	initial
	begin
		logic [31:0] e;
		logic [31:0] g;
		string       n;
		forever
		begin
			@(cmp_ev);
			while (exp_q.size() > 0)
			begin
				e = exp_q.pop_front();
				g = got_q.pop_front();
				n = name_q.pop_front();
				checks++;
				assert (g == e)
				else
				begin
					$display("[FAIL] %0t %s expected %h got %h", $time, n, e, g);
					errors++;
				end
			end
		end
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		logic [31:0] v;
		int          cnt;
		HSElx     = 1'b0;
		HADDR     = 32'h0;
		HTRANS    = IDLE;
		HWRITE    = 1'b0;
		HSIZE     = 3'd0;
		HWDATA    = 32'h0;
		HREADY    = 1'b1;
		seed      = 32'hf3b6f633;
		errors    = 0;
		checks    = 0;
		tests     = 0;
		test_base = 0;
		cur_init  = `CRC_INIT_RESET;
		cur_poly  = `CRC_POLY_RESET;
		cnt       = 0;
		while (HRESETn !== 1'b1 && cnt < 20)
		begin
			@(negedge HCLK);
			cnt++;
		end
		if (HRESETn !== 1'b1)
		begin
			$display("Reset was never released");
			$display("** FAIL **");
			$finish;
		end
		else
		begin
			// Reset values
			read_check(A_DR, "DR", `CRC_INIT_RESET);
			read_check(A_INIT, "INIT", `CRC_INIT_RESET);
			read_check(A_POL, "POL", `CRC_POLY_RESET);
			read_check(A_CR, "CR", {24'h0, `CRC_CR_RESET, 3'h0});
			read_check(A_IDR, "IDR", 32'h0);
			end_test("reset values");

			// Register access, CR shows only bits 7:3
			for (int i = 0; i < 4; i++)
			begin
				v = $random(seed);
				write_reg(A_IDR, 3'd2, v);
				read_check(A_IDR, "IDR", {24'h0, v[7:0]});
				write_reg(A_INIT, 3'd2, v);
				read_check(A_INIT, "INIT", v);
				write_reg(A_POL, 3'd2, ~v);
				read_check(A_POL, "POL", ~v);
				write_reg(A_CR, 3'd2, v);
				read_check(A_CR, "CR", v & 32'h0000_00F8);
				write_reg(A_UNMAP, 3'd2, v);
				read_check(A_UNMAP, "unmapped", 32'h0);
			end
			write_reg(A_INIT, 3'd2, cur_init);
			write_reg(A_POL, 3'd2, cur_poly);
			end_test("register access");

			// Word stream with default CRC-32, each write stalls on the busy engine
			restart_chain(2'd0, 2'd0, 1'b0);
			for (int i = 0; i < 20; i++)
				push_beat(3'd2, $random(seed));
			check_crc(2'd0, 2'd0, 1'b0);
			end_test("crc32 defaults");

			// Narrow widths with random generator and seed
			for (int ps = 1; ps < 4; ps++)
			begin
				cur_poly = $random(seed);
				cur_init = $random(seed);
				write_reg(A_POL, 3'd2, cur_poly);
				write_reg(A_INIT, 3'd2, cur_init);
				restart_chain(2'(ps), 2'd0, 1'b0);
				random_beats(12);
				check_crc(2'(ps), 2'd0, 1'b0);
			end
			end_test("poly sizes");

			// Every input reversal with output reversal off and on
			for (int rin = 0; rin < 4; rin++)
				for (int rout = 0; rout < 2; rout++)
				begin
					restart_chain(2'd0, 2'(rin), 1'(rout));
					random_beats(6);
					check_crc(2'd0, 2'(rin), 1'(rout));
				end
			end_test("reversal");

			// Restart lands while a word is still shifting
			restart_chain(2'd1, 2'd1, 1'b1);
			random_beats(3);
			write_reg(A_DR, 3'd2, $random(seed));
			restart_chain(2'd1, 2'd1, 1'b1);
			read_check(A_DR, "DR", crc_model(cur_poly, 16, cur_init, 2'd1, 1'b1,
				beat_data, beat_size));
			random_beats(5);
			check_crc(2'd1, 2'd1, 1'b1);
			end_test("chain restart");

			$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
			if (errors == 0)
				$display("** PASS **");
			else
				$display("** FAIL **");
			$finish;
		end
	end

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset source for the CRC engine
`timescale 1ns/1ns

module tb_clock_gen
(
	output logic HCLK,
	output logic HRESETn
);

	// 8 ns period
	initial
	begin
		HCLK = 1'b0;
		forever #4 HCLK = ~HCLK;
	end

	// Reset low for the first two rising edges
	initial
	begin
		HRESETn = 1'b0;
		repeat (2) @(posedge HCLK);
		HRESETn <= 1'b1;
	end

endmodule

// File: crc_ahb_top.sv
// AHB-Lite CRC engine top joining the bus front end and the datapath
`timescale 1ns/1ns

module crc_ahb_top
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSElx,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic        HWRITE,
	input  logic [2:0]  HSIZE,
	input  logic [31:0] HWDATA,
	input  logic        HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	import crc_pkg::*;

	// Front end to datapath
	logic [31:0] bus_wr;
	logic [1:0]  bus_size;
	logic        buffer_write_en;
	logic        crc_init_en;
	logic        crc_poly_en;
	logic        crc_idr_en;
	logic        reset_chain;
	poly_size_t  crc_poly_size;
	rev_in_t     rev_in_type;
	logic        rev_out_type;

	// Datapath back to front end
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0]  crc_idr_out;
	logic        buffer_full;
	logic        read_wait;
	logic        reset_pending;

	// On a single-slave bus HREADY is our own HREADYOUT fed back by the system
	host_interface u_host (.*);

	crc_datapath u_datapath (.*);

endmodule

// File: crc_datapath.sv
// CRC datapath with one-beat buffer, byte-serial engine and INIT POL IDR registers
`timescale 1ns/1ns
`include "crc_defines.svh"

module crc_datapath
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic [31:0]         bus_wr,
	input  logic [1:0]          bus_size,
	input  logic                buffer_write_en,
	input  logic                crc_init_en,
	input  logic                crc_poly_en,
	input  logic                crc_idr_en,
	input  logic                reset_chain,
	input  crc_pkg::poly_size_t crc_poly_size,
	input  crc_pkg::rev_in_t    rev_in_type,
	input  logic                rev_out_type,
	output logic [31:0]         crc_out,
	output logic [31:0]         crc_init_out,
	output logic [31:0]         crc_poly_out,
	output logic [7:0]          crc_idr_out,
	output logic                buffer_full,
	output logic                read_wait,
	output logic                reset_pending
);

	import crc_pkg::*;

	dp_state_t   state;
	logic [31:0] crc_q;
	// Beat left-aligned so the first byte sits in [31:24]
	logic [31:0] buf_data;
	// Number of bytes in the beat minus one
	logic [1:0]  beat_len;
	logic [1:0]  byte_sel;

	logic        load_beat;
	logic [31:0] rev_data;
	logic [31:0] aligned;
	logic [31:0] sel_shift;
	logic [7:0]  cur_byte;
	logic [4:0]  top_bit;
	logic [31:0] width_mask;
	logic [31:0] crc_masked;

	// Reverse bits within each group of w bits
	function automatic logic [31:0] reflect(input logic [31:0] d, input int w);
		logic [31:0] r;
		for (int i = 0; i < 32; i++)
			r[i] = d[(i / w) * w + (w - 1 - i % w)];
		return r;
	endfunction

	// Fold one byte into the CRC, MSB first
	function automatic logic [31:0] fold_byte(input logic [31:0] crc, input logic [7:0] data,
		input logic [31:0] poly, input logic [31:0] mask, input logic [4:0] top);
		logic [31:0] c;
		logic        fb;
		c = crc;
		for (int i = 7; i >= 0; i--)
		begin
			fb = c[top] ^ data[i];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	////////////////////////////////////////
	// Input buffer
	////////////////////////////////////////

	assign buffer_full = (state == DP_SHIFT);
	assign load_beat   = buffer_write_en && !buffer_full;

	// Reversal coarser than the beat is clipped to the beat width
	always_comb
	begin
		case (rev_in_type)
			REV_BYTE: rev_data = reflect(bus_wr, 8);
			REV_HALF: rev_data = (bus_size == 2'd0) ? reflect(bus_wr, 8) : reflect(bus_wr, 16);
			REV_WORD:
			begin
				if (bus_size == 2'd0)
					rev_data = reflect(bus_wr, 8);
				else if (bus_size == 2'd1)
					rev_data = reflect(bus_wr, 16);
				else
					rev_data = reflect(bus_wr, 32);
			end
			default: rev_data = bus_wr;
		endcase
		// Low lanes only, moved to the top
		case (bus_size)
			2'd0:    aligned = {rev_data[7:0], 24'h0};
			2'd1:    aligned = {rev_data[15:0], 16'h0};
			default: aligned = rev_data;
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (load_beat)
		begin
			buf_data <= aligned;
			beat_len <= bus_size[1] ? 2'd3 : {1'b0, bus_size[0]};
		end
	end

	////////////////////////////////////////
	// CRC engine
	////////////////////////////////////////

	always_comb
	begin
		case (crc_poly_size)
			POLY_16: top_bit = 5'd15;
			POLY_8:  top_bit = 5'd7;
			POLY_7:  top_bit = 5'd6;
			default: top_bit = 5'd31;
		endcase
	end

	assign width_mask = 32'hFFFF_FFFF >> (5'd31 - top_bit);
	assign sel_shift  = buf_data << {byte_sel, 3'b000};
	assign cur_byte   = sel_shift[31:24];

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state    <= DP_IDLE;
			byte_sel <= 2'd0;
		end
		else if (state == DP_IDLE)
		begin
			byte_sel <= 2'd0;
			if (load_beat)
				state <= DP_SHIFT;
		end
		else if (byte_sel == beat_len)
			state <= DP_IDLE;
		else
			byte_sel <= byte_sel + 2'd1;
	end

	// Restart while shifting waits for the beat to finish
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			reset_pending <= 1'b0;
		else if (state == DP_SHIFT && reset_chain)
			reset_pending <= 1'b1;
		else if (state == DP_IDLE)
			reset_pending <= 1'b0;
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_q <= `CRC_INIT_RESET;
		else if (state == DP_SHIFT)
			crc_q <= fold_byte(crc_q, cur_byte, crc_poly_out, width_mask, top_bit);
		else if (reset_chain || reset_pending)
			crc_q <= crc_init_out;
	end

	// Result is not valid until shifting and any restart are done
	assign read_wait  = buffer_full || reset_pending;
	assign crc_masked = crc_q & width_mask;
	assign crc_out    = rev_out_type ? (reflect(crc_masked, 32) >> (5'd31 - top_bit)) : crc_masked;

	////////////////////////////////////////
	// Configuration registers
	////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_init_out <= `CRC_INIT_RESET;
			crc_poly_out <= `CRC_POLY_RESET;
			crc_idr_out  <= 8'h00;
		end
		else
		begin
			// Old INIT must survive until the pending restart has used it
			if (crc_init_en && !reset_pending)
				crc_init_out <= bus_wr;
			if (crc_poly_en)
				crc_poly_out <= bus_wr;
			if (crc_idr_en)
				crc_idr_out <= bus_wr[7:0];
		end
	end

	// A DR write that meets a full buffer is held by the bus until it is taken
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(buffer_write_en && buffer_full) |=> buffer_write_en);

	// A word takes four shift cycles at most
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		$rose(state == DP_SHIFT) |-> ##[1:4] (state == DP_IDLE));

endmodule

// File: host_interface.sv
// AHB-Lite slave front end of the CRC engine with register decode and wait states
`timescale 1ns/1ns
`include "crc_defines.svh"

module host_interface
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  logic                HSElx,
	input  logic [31:0]         HADDR,
	input  logic [1:0]          HTRANS,
	input  logic                HWRITE,
	input  logic [2:0]          HSIZE,
	input  logic [31:0]         HWDATA,
	input  logic                HREADY,
	input  logic [31:0]         crc_out,
	input  logic [31:0]         crc_init_out,
	input  logic [31:0]         crc_poly_out,
	input  logic [7:0]          crc_idr_out,
	input  logic                buffer_full,
	input  logic                read_wait,
	input  logic                reset_pending,
	output logic [31:0]         HRDATA,
	output logic                HREADYOUT,
	output logic                HRESP,
	output logic [31:0]         bus_wr,
	output logic [1:0]          bus_size,
	output logic                buffer_write_en,
	output logic                crc_init_en,
	output logic                crc_poly_en,
	output logic                crc_idr_en,
	output logic                reset_chain,
	output crc_pkg::poly_size_t crc_poly_size,
	output crc_pkg::rev_in_t    rev_in_type,
	output logic                rev_out_type
);

	import crc_pkg::*;

	// Registered address phase
	crc_reg_t   haddr_pp;
	logic [1:0] hsize_pp;
	htrans_t    htrans_pp;
	logic       hwrite_pp;
	logic       hselx_pp;

	// CR fields as {rev_out, rev_in, poly_size}
	logic [4:0] crc_cr_ff;

	logic       sample_bus;
	logic       ahb_enable;
	logic       write_en;
	logic       read_en;
	logic       crc_cr_en;
	logic       buffer_read_en;
	logic       wr_en_any;

	////////////////////////////////////////
	// Address phase pipeline
	////////////////////////////////////////

	// Address phase is taken only when the bus and this slave are both ready
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= IDLE;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSElx;
			htrans_pp <= htrans_t'(HTRANS);
		end
	end

	// Address payload
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp  <= crc_reg_t'(HADDR[4:2]);
			hsize_pp  <= HSIZE[1:0];
			hwrite_pp <= HWRITE;
		end
	end

	////////////////////////////////////////
	// Decode and enables
	////////////////////////////////////////

	// Only NONSEQ acts, SEQ and BUSY fall through
	assign ahb_enable = (htrans_pp == NONSEQ);
	assign write_en   = hselx_pp && hwrite_pp && ahb_enable;
	assign read_en    = hselx_pp && !hwrite_pp && ahb_enable;

	assign buffer_write_en = write_en && (haddr_pp == REG_DR);
	assign crc_idr_en      = write_en && (haddr_pp == REG_IDR);
	assign crc_cr_en       = write_en && (haddr_pp == REG_CR);
	assign crc_init_en     = write_en && (haddr_pp == REG_INIT);
	assign crc_poly_en     = write_en && (haddr_pp == REG_POL);
	assign buffer_read_en  = read_en && (haddr_pp == REG_DR);
	assign wr_en_any       = buffer_write_en || crc_idr_en || crc_cr_en ||
	                         crc_init_en || crc_poly_en;

	// Write data belongs to the data phase and goes straight through
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	// Stall on full buffer, busy result or pending restart
	assign HREADYOUT = !((buffer_write_en && buffer_full) ||
	                     (buffer_read_en && read_wait) ||
	                     (crc_init_en && reset_pending));
	assign HRESP = 1'b0;

	////////////////////////////////////////
	// Control register
	////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_cr_ff <= `CRC_CR_RESET;
		else if (crc_cr_en)
			crc_cr_ff <= HWDATA[7:3];
	end

	// Bit 0 of a CR write restarts the chain and is not stored
	assign reset_chain   = crc_cr_en && HWDATA[0];
	assign crc_poly_size = poly_size_t'(crc_cr_ff[1:0]);
	assign rev_in_type   = rev_in_t'(crc_cr_ff[3:2]);
	assign rev_out_type  = crc_cr_ff[4];

	// Read data in the data phase
	always_comb
	begin
		case (haddr_pp)
			REG_DR:   HRDATA = crc_out;
			REG_IDR:  HRDATA = {24'h0, crc_idr_out};
			REG_CR:   HRDATA = {24'h0, crc_cr_ff, 3'h0};
			REG_INIT: HRDATA = crc_init_out;
			REG_POL:  HRDATA = crc_poly_out;
			default:  HRDATA = 32'h0;
		endcase
	end

	// An enable only follows a selected NONSEQ write address phase
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(wr_en_any && $past(sample_bus)) |-> $past(HSElx && HWRITE && (HTRANS == NONSEQ)));

	// A non-NONSEQ address phase never gets a wait state
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		$past(sample_bus && (HTRANS != NONSEQ)) |-> HREADYOUT);

endmodule

// File: crc_pkg.sv
// Types shared by the CRC bus decode and the CRC datapath
package crc_pkg;

	// AHB transfer type
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// Register offsets taken from HADDR[4:2]
	typedef enum logic [2:0] {
		REG_DR   = 3'd0,
		REG_IDR  = 3'd1,
		REG_CR   = 3'd2,
		REG_INIT = 3'd4,
		REG_POL  = 3'd5
	} crc_reg_t;

	// CRC width is 32 16 8 or 7 bits
	typedef enum logic [1:0] {POLY_32, POLY_16, POLY_8, POLY_7} poly_size_t;

	// Input bit reversal granularity
	typedef enum logic [1:0] {REV_NONE, REV_BYTE, REV_HALF, REV_WORD} rev_in_t;

	// Engine state
	typedef enum logic {
		DP_IDLE,
		DP_SHIFT
	} dp_state_t;

endpackage

// File: crc_defines.svh
// Reset values of the CRC engine registers
`ifndef CRC_DEFINES_SVH
`define CRC_DEFINES_SVH

// INIT seed of all ones
`define CRC_INIT_RESET 32'hFFFF_FFFF

// POL holds the standard CRC-32 generator
`define CRC_POLY_RESET 32'h04C1_1DB7

// CR cleared selects POLY_32 with no reversal
`define CRC_CR_RESET 5'h00

`endif
